//--- filelist.f
+incdir+.
marble_pkg.sv
reg_bus_if.sv
mmc_spi_port.sv
config_regs.sv
gmii_rx_monitor.sv
marble_core.sv
tb_marble_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_marble_core -f filelist.f &&
./obj_dir/Vtb_marble_core | tee /dev/stderr | grep -qx "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- tb_marble_core.sv
// Marble core testbench
`timescale 1ns/1ps
`include "marble_config.svh"

module tb_marble_core import marble_pkg::*;;

	localparam int half_period = 8;
	localparam int frame_gap   = 6;
	// Rough cycle budget per SPI transaction and per frame
	localparam int spi_cycles     = 280;
	localparam int frame_cycles   = 80;
	// Transactions and frames sent over all tests
	localparam int spi_xfers      = 47;
	localparam int frames_sent    = 25;
	localparam int timeout_cycles =
		2 * (spi_xfers * spi_cycles + frames_sent * frame_cycles + 20);

	logic       tx_clk;
	logic       rst_n;
	logic       sclk;
	logic       csb;
	logic       mosi;
	logic       miso;
	logic       mmc_int;
	logic [7:0] gmii_rxd;
	logic       gmii_rx_dv;
	logic       gmii_rx_er;
	logic [7:0] led;
	logic [7:0] ext_config;
	logic       vcxo_en;

	// Model registers and counters
	logic [7:0]  m_led;
	logic [7:0]  m_ext;
	logic        m_enable_rx;
	logic        m_int_en;
	logic        m_int;
	logic [15:0] m_frames;
	logic [7:0]  m_bad;
	logic [15:0] m_bytes;

	logic [31:0] lfsr;
	int          checks;
	int          errors;
	int          test_err_start;
	int          cycle_count;
	// Reads waiting for the comparison process
	logic [6:0]  addr_q[$];
	logic [7:0]  got_q[$];
	logic [7:0]  exp_q[$];

	marble_core u_dut (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.sclk       (sclk),
		.csb        (csb),
		.mosi       (mosi),
		.miso       (miso),
		.mmc_int    (mmc_int),
		.gmii_rxd   (gmii_rxd),
		.gmii_rx_dv (gmii_rx_dv),
		.gmii_rx_er (gmii_rx_er),
		.led        (led),
		.ext_config (ext_config),
		.vcxo_en    (vcxo_en)
	);

	always #20 tx_clk = ~tx_clk;

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic get_rand(input int nbits, output logic [31:0] value);
		value = 32'h0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	// Expected read value from the register map rules
	function automatic logic [7:0] expected_read(input logic [6:0] addr);
		case (addr)
			reg_id:         return `MARBLE_BOARD_ID;
			reg_led:        return m_led;
			reg_ext_config: return m_ext;
			reg_rx_ctrl:    return {5'b0, m_int_en, 1'b0, m_enable_rx};
			reg_frames_lo:  return m_frames[7:0];
			reg_frames_hi:  return m_frames[15:8];
			reg_bad_frames: return m_bad;
			reg_bytes_lo:   return m_bytes[7:0];
			default:        return 8'h00;
		endcase
	endfunction

	// Mode 0 transfer where nbits below 16 aborts the frame
	task automatic spi_xfer(input logic wr, input logic [6:0] addr, input logic [7:0] wdata,
			input int nbits, output logic [7:0] rdata);
		logic [15:0] word;
		word  = {wr, addr, wdata};
		rdata = 8'h00;
		@(posedge tx_clk);
		#2 csb = 1'b0;
		for (int i = 0; i < nbits; i++) begin
			mosi = word[15 - i];
			repeat (half_period) @(posedge tx_clk);
			#2;
			// MISO settled since the last falling edge
			if (i >= 8)
				rdata = {rdata[6:0], miso};
			sclk = 1'b1;
			repeat (half_period) @(posedge tx_clk);
			#2 sclk = 1'b0;
		end
		repeat (half_period) @(posedge tx_clk);
		#2 csb = 1'b1;
		mosi = 1'b0;
		repeat (half_period) @(posedge tx_clk);
	endtask

	task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		spi_xfer(1'b1, addr, data, 16, unused);
		case (addr)
			reg_led:        m_led = data;
			reg_ext_config: m_ext = data;
			reg_rx_ctrl: begin
				m_enable_rx = data[0];
				m_int_en    = data[2];
				if (data[1]) begin
					m_frames = 16'h0;
					m_bad    = 8'h0;
					m_bytes  = 16'h0;
					m_int    = 1'b0;
				end
			end
			default: ;
		endcase
	endtask

	task automatic spi_read(input logic [6:0] addr);
		logic [7:0] got;
		spi_xfer(1'b0, addr, 8'h00, 16, got);
		addr_q.push_back(addr);
		got_q.push_back(got);
		exp_q.push_back(expected_read(addr));
	endtask

	task automatic read_counters();
		spi_read(reg_frames_lo);
		spi_read(reg_frames_hi);
		spi_read(reg_bad_frames);
		spi_read(reg_bytes_lo);
	endtask

	// err_pos below zero gives a good frame
	task automatic send_frame(input int len, input int err_pos);
		logic [31:0] r;
		for (int i = 0; i < len; i++) begin
			@(posedge tx_clk);
			#2;
			get_rand(8, r);
			gmii_rxd   = r[7:0];
			gmii_rx_dv = 1'b1;
			gmii_rx_er = (i == err_pos);
		end
		@(posedge tx_clk);
		#2 gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		gmii_rxd   = 8'h00;
		repeat (frame_gap) @(posedge tx_clk);
		#2;
		if (m_enable_rx) begin
			m_bytes = m_bytes + 16'(len);
			if (err_pos >= 0) begin
				m_bad = m_bad + 8'd1;
			end else begin
				m_frames = m_frames + 16'd1;
				if (m_int_en)
					m_int = 1'b1;
			end
		end
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ports();
		check_value("led port", led, m_led);
		check_value("ext_config port", ext_config, m_ext);
		check_value("vcxo_en", {7'b0, vcxo_en}, {7'b0, ~m_ext[1]});
		check_value("mmc_int", {7'b0, mmc_int}, {7'b0, m_int});
	endtask

	// Let pending reads drain before the summary
	task automatic end_test(input string name);
		repeat (2) @(posedge tx_clk);
		#2;
		$display("%-28s %s, %0d errors", name,
			(errors == test_err_start) ? "passed" : "failed", errors - test_err_start);
		test_err_start = errors;
	endtask

	// Comparison of SPI reads with the model
	always @(posedge tx_clk) begin
		logic [6:0] a;
		logic [7:0] got;
		logic [7:0] exp;
		while (got_q.size() > 0) begin
			a   = addr_q.pop_front();
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			checks++;
			assert (got === exp) else begin
				errors++;
				$display("FAILED at %0d ns: read of register %0d gave %h, expected %h",
					$time, a, got, exp);
			end
		end
	end

	always @(posedge tx_clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		logic [7:0]  dummy;
		int          len;
		int          pos;
		tx_clk = 1'b0;
		rst_n = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		gmii_rxd = 8'h00;
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		lfsr = 32'h98ee9f27;
		checks = 0;
		errors = 0;
		test_err_start = 0;
		cycle_count = 0;
		m_led = `MARBLE_LED_DEFAULT;
		m_ext = `MARBLE_MISC_CONFIG_DEFAULT;
		m_enable_rx = `MARBLE_DEFAULT_ENABLE_RX;
		m_int_en = 1'b0;
		m_int = 1'b0;
		m_frames = 16'h0;
		m_bad = 8'h0;
		m_bytes = 16'h0;
		repeat (3) @(posedge tx_clk);
		#2 rst_n = 1'b1;

		// Reset values
		check_value("miso", {7'b0, miso}, 8'h00);
		check_ports();
		spi_read(reg_id);
		spi_read(reg_led);
		end_test("reset defaults");

		// Random led and ext_config writes
		for (int i = 0; i < 6; i++) begin
			get_rand(8, r);
			spi_write(reg_led, r[7:0]);
			get_rand(8, r);
			spi_write(reg_ext_config, r[7:0]);
			check_ports();
			spi_read(reg_led);
			spi_read(reg_ext_config);
		end
		end_test("led and ext_config");

		// Random frames with about one in four bad
		for (int i = 0; i < 20; i++) begin
			get_rand(6, r);
			len = int'(r[5:0]) + 1;
			get_rand(2, r);
			pos = -1;
			if (r[1:0] == 2'd0) begin
				get_rand(6, r);
				pos = int'(r[5:0]) % len;
			end
			send_frame(len, pos);
		end
		read_counters();
		end_test("frame counters");

		// Receive disabled
		spi_write(reg_rx_ctrl, 8'h00);
		send_frame(17, -1);
		send_frame(5, 2);
		send_frame(40, -1);
		read_counters();
		spi_write(reg_rx_ctrl, 8'h01);
		end_test("receive disabled");

		// Interrupt and clear
		spi_write(reg_rx_ctrl, 8'h07);
		send_frame(12, -1);
		check_ports();
		spi_write(reg_rx_ctrl, 8'h07);
		check_ports();
		send_frame(9, 4);
		check_ports();
		spi_read(reg_bad_frames);
		spi_read(reg_rx_ctrl);
		spi_write(reg_rx_ctrl, 8'h07);
		check_ports();
		read_counters();
		end_test("interrupt and clear");

		// Write cut short after 10 bits
		spi_xfer(1'b1, reg_led, ~m_led, 10, dummy);
		spi_read(reg_led);
		check_ports();
		end_test("aborted transaction");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- marble_core.sv
// Marble portable core
`timescale 1ns/1ps

module marble_core import marble_pkg::*; (
	input  logic       tx_clk,
	input  logic       rst_n,
	// SPI from the microcontroller
	input  logic       sclk,
	input  logic       csb,
	input  logic       mosi,
	output logic       miso,
	output logic       mmc_int,
	// GMII receive, already in the tx_clk domain
	input  logic [7:0] gmii_rxd,
	input  logic       gmii_rx_dv,
	input  logic       gmii_rx_er,
	output logic [7:0] led,
	output logic [7:0] ext_config,
	output logic       vcxo_en
);

	reg_bus_if  bus ();
	rx_counts_t counts;
	logic       enable_rx;
	logic       clear;

	mmc_spi_port u_spi (
		.tx_clk (tx_clk),
		.rst_n  (rst_n),
		.sclk   (sclk),
		.csb    (csb),
		.mosi   (mosi),
		.miso   (miso),
		.bus    (bus.master)
	);

	config_regs u_regs (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.bus        (bus.slave),
		.counts     (counts),
		.led        (led),
		.ext_config (ext_config),
		.enable_rx  (enable_rx),
		.clear      (clear),
		.mmc_int    (mmc_int)
	);

	gmii_rx_monitor u_rx_mon (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.gmii_rxd   (gmii_rxd),
		.gmii_rx_dv (gmii_rx_dv),
		.gmii_rx_er (gmii_rx_er),
		.enable_rx  (enable_rx),
		.clear      (clear),
		.counts     (counts)
	);

	// Setting ext_config bit 1 stops the VCXO
	assign vcxo_en = ~ext_config[1];

endmodule

//--- gmii_rx_monitor.sv
// GMII receive statistics
`timescale 1ns/1ps

module gmii_rx_monitor import marble_pkg::*; (
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic [7:0] gmii_rxd,
	input  logic       gmii_rx_dv,
	input  logic       gmii_rx_er,
	input  logic       enable_rx,
	input  logic       clear,
	output rx_counts_t counts
);

	// Previous rx_dv, marks the end of a frame
	logic dv_d;
	// Any rx_er seen in the current frame
	logic err_sticky;
	logic frame_start;
	logic frame_end;

	assign frame_start = gmii_rx_dv & ~dv_d;
	assign frame_end   = dv_d & ~gmii_rx_dv;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			dv_d       <= 1'b0;
			err_sticky <= 1'b0;
		end else begin
			dv_d <= gmii_rx_dv;
			// Restart the flag on each new frame
			if (frame_start) begin
				err_sticky <= gmii_rx_er;
			end else if (gmii_rx_dv) begin
				err_sticky <= err_sticky | gmii_rx_er;
			end
		end
	end

	// Counters step one cycle after rx_dv falls
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			counts <= '0;
		end else if (clear) begin
			counts <= '0;
		end else begin
			counts.frame_done <= 1'b0;
			if (enable_rx) begin
				// One byte per rx_dv cycle, wraps
				if (gmii_rx_dv) begin
					counts.bytes <= counts.bytes + 1'b1;
				end
				if (frame_end) begin
					counts.frame_done <= 1'b1;
					if (err_sticky) begin
						counts.bad_frames <= counts.bad_frames + 1'b1;
					end else begin
						counts.frames <= counts.frames + 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- config_regs.sv
// Control and status registers
`timescale 1ns/1ps
`include "marble_config.svh"

module config_regs import marble_pkg::*; (
	input  logic       tx_clk,
	input  logic       rst_n,
	reg_bus_if.slave   bus,
	input  rx_counts_t counts,
	output logic [7:0] led,
	output logic [7:0] ext_config,
	output logic       enable_rx,
	output logic       clear,
	output logic       mmc_int
);

	logic       int_enable;
	// Last cycle's bad-frame count, tells good from bad frames
	logic [7:0] bad_prev;
	logic       good_done;
	logic [7:0] rx_ctrl_rd;

	// Clear bit never reads back
	assign rx_ctrl_rd = {5'b0, int_enable, 1'b0, enable_rx};

	// Writes land the cycle after we
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			led        <= `MARBLE_LED_DEFAULT;
			ext_config <= `MARBLE_MISC_CONFIG_DEFAULT;
			enable_rx  <= `MARBLE_DEFAULT_ENABLE_RX;
			int_enable <= 1'b0;
			clear      <= 1'b0;
		end else begin
			clear <= 1'b0;
			if (bus.we) begin
				case (marble_reg_addr_e'(bus.addr))
					reg_led:        led <= bus.wdata;
					reg_ext_config: ext_config <= bus.wdata;
					reg_rx_ctrl: begin
						enable_rx  <= bus.wdata[0];
						clear      <= bus.wdata[1];
						int_enable <= bus.wdata[2];
					end
					default: ;
				endcase
			end
		end
	end

	// Read mux, registered on re
	always_ff @(posedge tx_clk) begin
		if (bus.re) begin
			case (marble_reg_addr_e'(bus.addr))
				reg_id:         bus.rdata <= `MARBLE_BOARD_ID;
				reg_led:        bus.rdata <= led;
				reg_ext_config: bus.rdata <= ext_config;
				reg_rx_ctrl:    bus.rdata <= rx_ctrl_rd;
				reg_frames_lo:  bus.rdata <= counts.frames[7:0];
				reg_frames_hi:  bus.rdata <= counts.frames[`MARBLE_CNT_W-1 -: 8];
				reg_bad_frames: bus.rdata <= counts.bad_frames;
				reg_bytes_lo:   bus.rdata <= counts.bytes[7:0];
				default:        bus.rdata <= 8'h00;
			endcase
		end
	end

	// A bad frame steps bad_frames in the same cycle as frame_done
	assign good_done = counts.frame_done && (counts.bad_frames == bad_prev);

	always_ff @(posedge tx_clk) begin
		bad_prev <= counts.bad_frames;
	end

	// Level interrupt, held until cleared
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			mmc_int <= 1'b0;
		end else if (clear) begin
			mmc_int <= 1'b0;
		end else if (good_done && int_enable) begin
			mmc_int <= 1'b1;
		end
	end

endmodule

//--- mmc_spi_port.sv
// Microcontroller SPI slave
`timescale 1ns/1ps

module mmc_spi_port (
	input  logic      tx_clk,
	input  logic      rst_n,
	input  logic      sclk,
	input  logic      csb,
	input  logic      mosi,
	output logic      miso,
	reg_bus_if.master bus
);

	// Extra SCLK stage holds the previous level for edge detection
	logic [2:0] sclk_sync;
	logic [1:0] csb_sync;
	logic [1:0] mosi_sync;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       csb_s;
	logic       mosi_s;
	// Bits seen in this frame, stops at 16
	logic [4:0] bit_cnt;
	logic [6:0] shift_in;
	logic       is_write;
	logic [6:0] addr_q;
	logic [7:0] wdata_q;
	logic       we_q;
	logic       re_q;
	// rdata is valid while re_d is high
	logic       re_d;
	logic [7:0] miso_sr;
	logic       data_phase;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			sclk_sync <= 3'b000;
			csb_sync  <= 2'b11;
			mosi_sync <= 2'b00;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			csb_sync  <= {csb_sync[0], csb};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign csb_s     = csb_sync[1];
	assign mosi_s    = mosi_sync[1];

	// Read data goes out after the eighth bit
	assign data_phase = (bit_cnt >= 5'd8) && (bit_cnt < 5'd16);

	// CSB high abandons any partial transaction
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			bit_cnt <= 5'd0;
		end else if (csb_s) begin
			bit_cnt <= 5'd0;
		end else if (sclk_rise && bit_cnt != 5'd16) begin
			bit_cnt <= bit_cnt + 5'd1;
		end
	end

	// MSB first, sampled on the synchronized rising edge
	always_ff @(posedge tx_clk) begin
		if (sclk_rise && !csb_s) begin
			shift_in <= {shift_in[5:0], mosi_s};
		end
	end

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			is_write <= 1'b0;
			re_q     <= 1'b0;
			we_q     <= 1'b0;
			re_d     <= 1'b0;
		end else begin
			re_q <= 1'b0;
			we_q <= 1'b0;
			re_d <= re_q;
			if (!csb_s && sclk_rise) begin
				// Eighth bit completes command and address
				if (bit_cnt == 5'd7) begin
					is_write <= shift_in[6];
					re_q     <= ~shift_in[6];
				end
				if (bit_cnt == 5'd15) begin
					we_q <= is_write;
				end
			end
		end
	end

	// Address and data words
	always_ff @(posedge tx_clk) begin
		if (!csb_s && sclk_rise && bit_cnt == 5'd7) begin
			addr_q <= {shift_in[5:0], mosi_s};
		end
		if (!csb_s && sclk_rise && bit_cnt == 5'd15) begin
			wdata_q <= {shift_in, mosi_s};
		end
	end

	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;
	assign bus.we    = we_q;
	assign bus.re    = re_q;

	// MISO moves on falling edges, bit 7 first
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			miso    <= 1'b0;
			miso_sr <= 8'h00;
		end else if (csb_s) begin
			miso    <= 1'b0;
			miso_sr <= 8'h00;
		end else if (re_d) begin
			miso_sr <= bus.rdata;
		end else if (sclk_fall && data_phase) begin
			miso    <= miso_sr[7];
			miso_sr <= {miso_sr[6:0], 1'b0};
		end
	end

endmodule

//--- reg_bus_if.sv
// Register access bus
`timescale 1ns/1ps

interface reg_bus_if;

	// Register address, 7 bits as in the SPI command word
	logic [6:0] addr;
	// Write data, used only with we
	logic [7:0] wdata;
	// One-cycle strobes
	logic       we;
	logic       re;
	// Read data, valid the cycle after re
	logic [7:0] rdata;

	// SPI side
	modport master (
		output addr,
		output wdata,
		output we,
		output re,
		input  rdata
	);

	// Register file side
	modport slave (
		input  addr,
		input  wdata,
		input  we,
		input  re,
		output rdata
	);

endinterface

//--- marble_pkg.sv
// Marble core shared types
`include "marble_config.svh"

package marble_pkg;

	// Register map seen from the microcontroller
	typedef enum logic [6:0] {
		reg_id         = 7'd0,
		reg_led        = 7'd1,
		reg_ext_config = 7'd2,
		reg_rx_ctrl    = 7'd3,
		reg_frames_lo  = 7'd4,
		reg_frames_hi  = 7'd5,
		reg_bad_frames = 7'd6,
		reg_bytes_lo   = 7'd7
	} marble_reg_addr_e;

	// Receive statistics, monitor to register file
	typedef struct packed {
		logic [`MARBLE_CNT_W-1:0] frames;
		logic [7:0]               bad_frames;
		logic [`MARBLE_CNT_W-1:0] bytes;
		// One-cycle pulse when a counter has just stepped
		logic                     frame_done;
	} rx_counts_t;

endpackage

//--- marble_config.svh
// Board build configuration
`ifndef MARBLE_CONFIG_SVH
`define MARBLE_CONFIG_SVH

// Value returned by the read-only id register
`define MARBLE_BOARD_ID 8'h4d

// LED pattern out of reset
`define MARBLE_LED_DEFAULT 8'h00

// External configuration out of reset
// Bit 1 low keeps the VCXO running
`define MARBLE_MISC_CONFIG_DEFAULT 8'h00

// Receive monitor starts enabled
`define MARBLE_DEFAULT_ENABLE_RX 1'b1

// Frame and byte counter width
`define MARBLE_CNT_W 16

`endif
